// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_evreq
FILELIST  = evreq.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== evreq.f ====
evreq_pkg.sv
evreq_sync_fifo.sv
evreq_cmd_gen.sv
evreq_status_track.sv
evreq_req_gen.sv
tb_evreq_checker.sv
tb_evreq.sv

// ==== evreq_cmd_gen.sv ====
module evreq_cmd_gen (
    input  logic                   memclk,
    input  logic                   memresetn,
    input  logic                   payload_valid_i,
    input  evreq_pkg::ident_t      payload_ident_i,
    input  logic                   payload_last_i,
    input  evreq_pkg::evt_addr_t   done_addr_i,
    input  logic                   done_valid_i,
    output logic                   payload_has_space_o,
    output evreq_pkg::cmd_entry_t  entry_o,
    output logic                   entry_wr_o,
    output logic                   final_wr_o
);

    import evreq_pkg::*;

    gen_state_t state_q;
    gen_state_t state_d;

    // kb offset of the transfer in progress
    kb_addr_t kb_addr_q;
    kb_addr_t chunk_start;
    kb_addr_t addend_a;
    kb_addr_t addend_b;

    logic [2:0] surf;
    logic [1:0] chunk;
    logic       last_surf;
    logic       final_cmd;
    logic       last_beat;

    assign surf  = payload_ident_i[2:0];
    assign chunk = payload_ident_i[4:3];

    // ident order is surf 0..6 of chunk 0, then chunk 1, ...
    assign last_surf = (surf == 3'(LAST_SURF));
    assign final_cmd = last_surf && (chunk == 2'(LAST_CHUNK));
    assign last_beat = payload_valid_i && payload_last_i;

    ////////////////////
    // address adder
    ////////////////////

    // base is in 4 kB pages, so x4 gives kB
    assign chunk_start = kb_addr_t'(BASE_ADDRESS_4KB * 4 + CHUNK_SIZE_KB * chunk);

    // one adder covers both the chunk load and the surf step
    assign addend_a = (state_q == LOAD_BASE) ? chunk_start : kb_addr_q;
    assign addend_b = (state_q == INCR_ADDR) ? kb_addr_t'(SURF_SIZE_KB) : '0;

    always_ff @(posedge memclk) begin
        if (state_q == LOAD_BASE || state_q == INCR_ADDR) begin
            kb_addr_q <= addend_a + addend_b;
        end
    end

    ////////////////////
    // control fsm
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            // need both a chunk and somewhere to put it
            IDLE: begin
                if (payload_valid_i && done_valid_i) begin
                    state_d = LOAD_BASE;
                end
            end
            LOAD_BASE: begin
                state_d = WAIT_LAST;
            end
            WAIT_LAST: begin
                if (last_beat) begin
                    if (final_cmd) begin
                        state_d = IDLE;
                    end else if (last_surf) begin
                        // chunk done, next one starts from a fresh base
                        state_d = WAIT_NEXT_CHUNK;
                    end else begin
                        state_d = INCR_ADDR;
                    end
                end
            end
            INCR_ADDR: begin
                state_d = WAIT_LAST;
            end
            WAIT_NEXT_CHUNK: begin
                // address is still held from this event
                if (payload_valid_i) begin
                    state_d = LOAD_BASE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // one entry per surf chunk, written on its last beat
    assign entry_wr_o = (state_q == WAIT_LAST) && last_beat;
    assign final_wr_o = entry_wr_o && final_cmd;
    // done address is held by its source until the final write
    assign entry_o    = {final_cmd, done_addr_i, kb_addr_q};

    assign payload_has_space_o = (state_q == WAIT_NEXT_CHUNK) ||
                                 ((state_q == IDLE) && done_valid_i);

endmodule

// ==== evreq_pkg.sv ====
package evreq_pkg;

    ////////////////////
    // widths
    ////////////////////

    // payload identity, surf number in 2:0 and chunk number in 4:3
    typedef logic [4:0]  ident_t;
    // event address is memory address bits 31:19
    typedef logic [12:0] evt_addr_t;
    // kb offset of a transfer inside the event
    typedef logic [8:0]  kb_addr_t;
    // command fifo entry: final flag, event address, kb offset
    typedef logic [22:0] cmd_entry_t;
    typedef logic [71:0] dm_cmd_t;
    // status: bit 7 ok, 6:4 errors, bit 0 final
    typedef logic [7:0]  dm_stat_t;
    typedef logic [3:0]  err_flags_t;
    // completion: event address in 44:32, error data in 31:0
    typedef logic [63:0] cmpl_t;

    ////////////////////
    // address map
    ////////////////////

    // event data starts at this many 4 kB pages into the event
    localparam int BASE_ADDRESS_4KB = 4;
    localparam int CHUNK_SIZE_KB    = 4;
    // one surf spans all four of its chunks
    localparam int SURF_SIZE_KB     = 16;
    // bytes per data-mover transfer
    localparam int CHUNK_BTT        = 4096;
    localparam int LAST_SURF        = 6;
    localparam int LAST_CHUNK       = 3;
    // 7 surfs x 4 chunks per event
    localparam int NUM_XFERS        = 28;

    // buffering
    localparam int CMD_FIFO_DEPTH   = 32;
    localparam int DONE_FIFO_DEPTH  = 4;
    localparam int CMPL_FIFO_DEPTH  = 4;

    // request generator states
    typedef enum logic [2:0] {
        IDLE,
        LOAD_BASE,
        WAIT_LAST,
        INCR_ADDR,
        WAIT_NEXT_CHUNK
    } gen_state_t;

endpackage

// ==== evreq_req_gen.sv ====
module evreq_req_gen (
    input  logic                   memclk,
    input  logic                   memresetn,
    // payload framing
    input  logic                   payload_valid_i,
    input  evreq_pkg::ident_t      payload_ident_i,
    input  logic                   payload_last_i,
    output logic                   payload_has_space_o,
    // event addresses
    input  evreq_pkg::evt_addr_t   done_addr_i,
    input  logic                   done_valid_i,
    output logic                   done_ready_o,
    // data-mover command and status
    output evreq_pkg::dm_cmd_t     dm_cmd_o,
    output logic                   dm_cmd_valid_o,
    input  logic                   dm_cmd_ready_i,
    input  evreq_pkg::dm_stat_t    dm_stat_i,
    input  logic                   dm_stat_valid_i,
    // completions
    output evreq_pkg::cmpl_t       cmpl_o,
    output logic                   cmpl_valid_o,
    input  logic                   cmpl_ready_i,
    output evreq_pkg::err_flags_t  cmd_err_o
);

    import evreq_pkg::*;

    cmd_entry_t entry;
    cmd_entry_t cmd_head;
    logic       entry_wr;
    logic       final_wr;
    logic       cmd_rd;
    logic       cmd_ovf;

    evt_addr_t  done_head;
    logic       done_rd;
    logic       done_ovf;
    logic       done_unf;

    cmpl_t      cmpl_in;
    logic       cmpl_wr;
    logic       cmpl_rd;
    logic       cmpl_ovf;

    logic [31:0] dm_lower;
    logic [31:0] dm_addr;
    logic [7:0]  dm_tag_byte;

    evreq_cmd_gen u_cmd_gen (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .payload_valid_i     (payload_valid_i),
        .payload_ident_i     (payload_ident_i),
        .payload_last_i      (payload_last_i),
        .done_addr_i         (done_addr_i),
        .done_valid_i        (done_valid_i),
        .payload_has_space_o (payload_has_space_o),
        .entry_o             (entry),
        .entry_wr_o          (entry_wr),
        .final_wr_o          (final_wr)
    );

    ////////////////////
    // command path
    ////////////////////

    evreq_sync_fifo #(
        .WIDTH ($bits(cmd_entry_t)),
        .DEPTH (CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .din_i       (entry),
        .wr_en_i     (entry_wr),
        .rd_en_i     (cmd_rd),
        .dout_o      (cmd_head),
        .valid_o     (dm_cmd_valid_o),
        .overflow_o  (cmd_ovf),
        .underflow_o ()
    );

    assign cmd_rd = dm_cmd_valid_o && dm_cmd_ready_i;

    // lower word never changes: no realign, eof set, incrementing, fixed btt
    assign dm_lower    = {1'b0, 1'b1, 6'b000000, 1'b1, 23'(CHUNK_BTT)};
    // event address and kb offset, 1 kB aligned
    assign dm_addr     = {cmd_head[21:0], 10'b0};
    // tag marks the event's final transfer
    assign dm_tag_byte = {7'b0, cmd_head[22]};
    assign dm_cmd_o    = {dm_tag_byte, dm_addr, dm_lower};

    ////////////////////
    // done addresses
    ////////////////////

    // address is consumed when its last command goes in
    assign done_ready_o = final_wr;

    evreq_sync_fifo #(
        .WIDTH ($bits(evt_addr_t)),
        .DEPTH (DONE_FIFO_DEPTH)
    ) u_done_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .din_i       (done_addr_i),
        .wr_en_i     (final_wr),
        .rd_en_i     (done_rd),
        .dout_o      (done_head),
        .valid_o     (),
        .overflow_o  (done_ovf),
        .underflow_o (done_unf)
    );

    ////////////////////
    // status and completions
    ////////////////////

    evreq_status_track u_status_track (
        .memclk          (memclk),
        .memresetn       (memresetn),
        .dm_stat_i       (dm_stat_i),
        .dm_stat_valid_i (dm_stat_valid_i),
        .done_head_i     (done_head),
        .done_rd_o       (done_rd),
        .cmpl_o          (cmpl_in),
        .cmpl_wr_o       (cmpl_wr),
        .cmd_ovf_i       (cmd_ovf),
        .done_ovf_i      (done_ovf),
        .cmpl_ovf_i      (cmpl_ovf),
        .done_unf_i      (done_unf),
        .cmd_err_o       (cmd_err_o)
    );

    evreq_sync_fifo #(
        .WIDTH ($bits(cmpl_t)),
        .DEPTH (CMPL_FIFO_DEPTH)
    ) u_cmpl_fifo (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .din_i       (cmpl_in),
        .wr_en_i     (cmpl_wr),
        .rd_en_i     (cmpl_rd),
        .dout_o      (cmpl_o),
        .valid_o     (cmpl_valid_o),
        .overflow_o  (cmpl_ovf),
        .underflow_o ()
    );

    assign cmpl_rd = cmpl_valid_o && cmpl_ready_i;

endmodule

// ==== evreq_status_track.sv ====
module evreq_status_track (
    input  logic                   memclk,
    input  logic                   memresetn,
    input  evreq_pkg::dm_stat_t    dm_stat_i,
    input  logic                   dm_stat_valid_i,
    input  evreq_pkg::evt_addr_t   done_head_i,
    output logic                   done_rd_o,
    output evreq_pkg::cmpl_t       cmpl_o,
    output logic                   cmpl_wr_o,
    input  logic                   cmd_ovf_i,
    input  logic                   done_ovf_i,
    input  logic                   cmpl_ovf_i,
    input  logic                   done_unf_i,
    output evreq_pkg::err_flags_t  cmd_err_o
);

    import evreq_pkg::*;

    // status bits recast as errors, ok bit inverted
    err_flags_t cur_err;
    logic       err_any;
    logic       final_stat;
    logic       stat_beat;

    // sticky status errors for the event
    err_flags_t stat_err_q;
    // one bit per transfer, last one comes from the live status
    logic [NUM_XFERS-2:0] xfer_rec_q;
    logic [31:0]          err_data;

    // sticky fifo errors
    err_flags_t fifo_err_q;

    assign stat_beat  = dm_stat_valid_i;
    assign cur_err    = {!dm_stat_i[7], dm_stat_i[6:4]};
    assign err_any    = |cur_err;
    assign final_stat = dm_stat_i[0];

    ////////////////////
    // status folding
    ////////////////////

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            stat_err_q <= '0;
            xfer_rec_q <= '0;
        end else if (stat_beat) begin
            // flags restart with every event
            if (final_stat) begin
                stat_err_q <= '0;
            end else begin
                stat_err_q <= stat_err_q | cur_err;
            end
            // oldest transfer ends up at bit 0
            xfer_rec_q <= {err_any, xfer_rec_q[NUM_XFERS-2:1]};
        end
    end

    // final transfer at 31, record, then folded flags
    assign err_data = {err_any, xfer_rec_q, stat_err_q | cur_err};

    // completion goes out with the final status
    assign cmpl_wr_o = stat_beat && final_stat;
    assign done_rd_o = stat_beat && final_stat;
    // upper bits stay zero
    assign cmpl_o    = cmpl_t'({done_head_i, err_data});

    ////////////////////
    // fifo errors
    ////////////////////

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            fifo_err_q <= '0;
        end else begin
            // bit 0 command fifo full
            if (cmd_ovf_i) begin
                fifo_err_q[0] <= 1'b1;
            end
            // bit 1 done-address fifo full
            if (done_ovf_i) begin
                fifo_err_q[1] <= 1'b1;
            end
            // bit 2 completion fifo full
            if (cmpl_ovf_i) begin
                fifo_err_q[2] <= 1'b1;
            end
            // bit 3 final status with no event pending
            if (done_unf_i) begin
                fifo_err_q[3] <= 1'b1;
            end
        end
    end

    assign cmd_err_o = fifo_err_q;

endmodule

// ==== evreq_sync_fifo.sv ====
module evreq_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             memclk,
    input  logic             memresetn,
    input  logic [WIDTH-1:0] din_i,
    input  logic             wr_en_i,
    input  logic             rd_en_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             valid_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    localparam int AW = $clog2(DEPTH);

    // storage behind the output register
    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [AW:0]      mem_cnt_q;
    // head of the fifo, shown ahead of the read
    logic [WIDTH-1:0] dout_q;
    logic             valid_q;

    logic [AW:0] occupancy;
    logic        full;
    logic        pop;
    logic        load;
    logic        wr_ok;
    logic        bypass;
    logic        mem_wr;
    logic        mem_rd;

    // output register counts as one entry
    assign occupancy = mem_cnt_q + (AW+1)'(valid_q);
    assign full      = (occupancy == (AW+1)'(DEPTH));
    assign pop       = rd_en_i && valid_q;
    // head register is free, or being freed this cycle
    assign load      = !valid_q || pop;
    // full fifo drops the write
    assign wr_ok     = wr_en_i && !full;
    // empty storage: write goes straight to the head
    assign bypass    = wr_ok && load && (mem_cnt_q == '0);
    assign mem_wr    = wr_ok && !bypass;
    assign mem_rd    = load && (mem_cnt_q != '0);

    always_ff @(posedge memclk) begin
        if (mem_wr) begin
            mem[wr_ptr_q] <= din_i;
        end
        if (bypass) begin
            dout_q <= din_i;
        end else if (mem_rd) begin
            dout_q <= mem[rd_ptr_q];
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            mem_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (mem_wr && !mem_rd) begin
                mem_cnt_q <= mem_cnt_q + 1'b1;
            end else if (mem_rd && !mem_wr) begin
                mem_cnt_q <= mem_cnt_q - 1'b1;
            end
            if (load) begin
                valid_q <= bypass || mem_rd;
            end
        end
    end

    assign dout_o      = dout_q;
    assign valid_o     = valid_q;
    // error pulses
    assign overflow_o  = wr_en_i && full;
    assign underflow_o = rd_en_i && !valid_q;

endmodule

// ==== tb_evreq.sv ====
module tb_evreq;

    import evreq_pkg::*;

    localparam int NUM_EVENTS     = 4;
    // each transfer gets a generous dozen cycles
    localparam int TIMEOUT_CYCLES = NUM_EVENTS * NUM_XFERS * 12 + 500;
    // no realign, eof set, incrementing burst, 4096 bytes
    localparam logic [31:0] CMD_LOWER = {1'b0, 1'b1, 6'd0, 1'b1, 23'd4096};

    logic       memclk;
    logic       memresetn;
    logic       payload_valid;
    ident_t     payload_ident;
    logic       payload_last;
    logic       payload_has_space;
    evt_addr_t  done_addr;
    logic       done_valid;
    logic       done_ready;
    dm_cmd_t    dm_cmd;
    logic       dm_cmd_valid;
    logic       dm_cmd_ready;
    dm_stat_t   dm_stat;
    logic       dm_stat_valid;
    cmpl_t      cmpl;
    logic       cmpl_valid;
    logic       cmpl_ready;
    err_flags_t cmd_err;

    ////////////////////
    // event table
    ////////////////////

    // name, done address, error mask per transfer, error code, hold commands
    string       tbl_name [NUM_EVENTS] = '{"clean event", "error event",
                                           "flags cleared", "command back-pressure"};
    evt_addr_t   tbl_addr [NUM_EVENTS] = '{13'h0a5, 13'h1c3, 13'h0f0, 13'h1ff};
    logic [27:0] tbl_mask [NUM_EVENTS] = '{28'h0000000, 28'h8000401, 28'h0002000, 28'h4000001};
    logic [2:0]  tbl_code [NUM_EVENTS] = '{3'b000, 3'b101, 3'b010, 3'b100};
    logic        tbl_hold [NUM_EVENTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

    // expected commands and the status each one earns
    dm_cmd_t  exp_cmd_q [$];
    dm_stat_t resp_q [$];
    // statuses on their way back to the DUT
    dm_stat_t stat_q [$];

    logic        hold_cmd;
    logic [31:0] lcg_state = 32'h7e27_6d88;
    string       cur_test;
    int          check_errs   = 0;
    int          test_mark    = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_cnt    = 0;

    initial memclk = 1'b0;
    always #5 memclk = ~memclk;

    evreq_req_gen u_dut (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .payload_valid_i     (payload_valid),
        .payload_ident_i     (payload_ident),
        .payload_last_i      (payload_last),
        .payload_has_space_o (payload_has_space),
        .done_addr_i         (done_addr),
        .done_valid_i        (done_valid),
        .done_ready_o        (done_ready),
        .dm_cmd_o            (dm_cmd),
        .dm_cmd_valid_o      (dm_cmd_valid),
        .dm_cmd_ready_i      (dm_cmd_ready),
        .dm_stat_i           (dm_stat),
        .dm_stat_valid_i     (dm_stat_valid),
        .cmpl_o              (cmpl),
        .cmpl_valid_o        (cmpl_valid),
        .cmpl_ready_i        (cmpl_ready),
        .cmd_err_o           (cmd_err)
    );

    always @(posedge memclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // kb offset is base 16, plus 4 per chunk, plus 16 per surf
    function automatic dm_cmd_t expect_cmd(evt_addr_t addr, int chunk, int surf);
        logic [8:0] kb;
        logic       fin;
        kb  = 9'(16 + 4 * chunk + 16 * surf);
        fin = (chunk == 3) && (surf == 6);
        return {7'b0, fin, addr, kb, 10'b0, CMD_LOWER};
    endfunction

    // ok bit clear and the code on an error, ok bit alone otherwise
    function automatic dm_stat_t status_for(logic err, logic [2:0] code, logic fin);
        return err ? {1'b0, code, 3'b000, fin} : {1'b1, 3'b000, 3'b000, fin};
    endfunction

    // transfer k lands at bit k+4, flags are not-ok plus the code
    function automatic cmpl_t expect_cmpl(evt_addr_t addr, logic [27:0] mask, logic [2:0] code);
        logic [3:0] flags;
        flags = (mask != 28'd0) ? {1'b1, code} : 4'b0000;
        return {19'b0, addr, mask, flags};
    endfunction

    task automatic start_test(string name);
        cur_test  = name;
        test_mark = check_errs;
    endtask

    task automatic finish_test();
        tests_run++;
        if (check_errs == test_mark) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, check_errs - test_mark);
            tests_failed++;
        end
    endtask

    task automatic drive_beat(ident_t ident, logic last);
        @(posedge memclk);
        #1;
        payload_valid = 1'b1;
        payload_ident = ident;
        payload_last  = last;
    endtask

    task automatic wait_space();
        @(negedge memclk);
        while (!payload_has_space) begin
            @(negedge memclk);
        end
    endtask

    task automatic queue_expected(int ev);
        int c;
        int s;
        for (c = 0; c < 4; c++) begin
            for (s = 0; s < 7; s++) begin
                exp_cmd_q.push_back(expect_cmd(tbl_addr[ev], c, s));
                resp_q.push_back(status_for(tbl_mask[ev][c * 7 + s], tbl_code[ev],
                                            (c == 3) && (s == 6)));
            end
        end
    endtask

    ////////////////////
    // payload source
    ////////////////////

    task automatic send_event(int ev);
        ident_t ident;
        int     c;
        int     s;
        @(posedge memclk);
        #1;
        done_addr  = tbl_addr[ev];
        done_valid = 1'b1;
        for (c = 0; c < 4; c++) begin
            // a chunk may only start while there is space
            wait_space();
            for (s = 0; s < 7; s++) begin
                ident = {2'(c), 3'(s)};
                drive_beat(ident, 1'b0);
                drive_beat(ident, 1'b0);
                drive_beat(ident, 1'b1);
            end
            if (c == 3) begin
                @(negedge memclk);
                // final command takes the done address
                if (done_ready !== 1'b1) begin
                    $display("FAILED %s done ready: expected 1 actual %b", cur_test, done_ready);
                    check_errs++;
                end
            end
            @(posedge memclk);
            #1;
            payload_valid = 1'b0;
            payload_last  = 1'b0;
        end
        done_valid = 1'b0;
    endtask

    task automatic take_completion(output cmpl_t word);
        @(negedge memclk);
        while (!cmpl_valid) begin
            @(negedge memclk);
        end
        // leave it stalled for a couple of cycles
        repeat (2) @(negedge memclk);
        word = cmpl;
        @(posedge memclk);
        #1;
        cmpl_ready = 1'b1;
        @(posedge memclk);
        #1;
        cmpl_ready = 1'b0;
    endtask

    ////////////////////
    // data mover model
    ////////////////////

    initial begin
        dm_cmd_t exp_c;
        dm_cmd_ready  = 1'b0;
        dm_stat       = '0;
        dm_stat_valid = 1'b0;
        forever begin
            @(posedge memclk);
            #1;
            // one status per cycle, in command order
            if (stat_q.size() > 0) begin
                dm_stat       = stat_q.pop_front();
                dm_stat_valid = 1'b1;
            end else begin
                dm_stat       = '0;
                dm_stat_valid = 1'b0;
            end
            // random stalls, or a full stop while a test holds commands
            dm_cmd_ready = !hold_cmd && (lcg_next() >= 32'h4000_0000);
            @(negedge memclk);
            if (dm_cmd_valid && dm_cmd_ready) begin
                if (exp_cmd_q.size() == 0) begin
                    $display("unexpected command %h came out of the DUT", dm_cmd);
                    check_errs++;
                end else begin
                    exp_c = exp_cmd_q.pop_front();
                    stat_q.push_back(resp_q.pop_front());
                    if (dm_cmd !== exp_c) begin
                        $display("FAILED %s command: expected %h actual %h",
                                 cur_test, exp_c, dm_cmd);
                        check_errs++;
                    end
                end
            end
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        cmpl_t got;
        cmpl_t want;
        int    ev;
        memresetn     = 1'b0;
        payload_valid = 1'b0;
        payload_ident = '0;
        payload_last  = 1'b0;
        done_addr     = '0;
        done_valid    = 1'b0;
        cmpl_ready    = 1'b0;
        hold_cmd      = 1'b0;
        repeat (16) @(posedge memclk);
        #1;
        memresetn = 1'b1;

        start_test("reset values");
        @(negedge memclk);
        if ({dm_cmd_valid, cmpl_valid, done_ready, payload_has_space, cmd_err} !== 8'h00) begin
            $display("FAILED %s: expected %h actual %h", cur_test, 8'h00,
                     {dm_cmd_valid, cmpl_valid, done_ready, payload_has_space, cmd_err});
            check_errs++;
        end
        finish_test();

        // idle space follows the done address alone
        start_test("space signal");
        repeat (3) @(negedge memclk);
        if (payload_has_space !== 1'b0) begin
            $display("FAILED %s without address: expected 0 actual %b", cur_test, payload_has_space);
            check_errs++;
        end
        @(posedge memclk);
        #1;
        done_addr  = tbl_addr[0];
        done_valid = 1'b1;
        @(negedge memclk);
        if (payload_has_space !== 1'b1) begin
            $display("FAILED %s with address: expected 1 actual %b", cur_test, payload_has_space);
            check_errs++;
        end
        @(posedge memclk);
        #1;
        done_valid = 1'b0;
        finish_test();

        for (ev = 0; ev < NUM_EVENTS; ev++) begin
            start_test(tbl_name[ev]);
            @(negedge memclk);
            hold_cmd = tbl_hold[ev];
            queue_expected(ev);
            send_event(ev);
            if (tbl_hold[ev]) begin
                repeat (4) @(negedge memclk);
                // oldest command of the parked event waits at the head
                if (dm_cmd_valid !== 1'b1) begin
                    $display("%s: no command waiting while the data mover stalls", cur_test);
                    check_errs++;
                end else if (dm_cmd !== exp_cmd_q[0]) begin
                    $display("FAILED %s waiting command: expected %h actual %h",
                             cur_test, exp_cmd_q[0], dm_cmd);
                    check_errs++;
                end
                hold_cmd = 1'b0;
            end
            take_completion(got);
            want = expect_cmpl(tbl_addr[ev], tbl_mask[ev], tbl_code[ev]);
            if (got !== want) begin
                $display("FAILED %s completion: expected %h actual %h", cur_test, want, got);
                check_errs++;
            end
            if (exp_cmd_q.size() != 0) begin
                $display("%s: completion arrived before every command was seen", cur_test);
                check_errs++;
            end
            if (cmd_err !== 4'b0000) begin
                $display("FAILED %s fifo errors: expected %b actual %b", cur_test, 4'b0000, cmd_err);
                check_errs++;
            end
            finish_test();
        end

        // final status with nothing pending
        start_test("doneaddr underflow");
        @(negedge memclk);
        stat_q.push_back(status_for(1'b0, 3'b000, 1'b1));
        take_completion(got);
        if (cmd_err !== 4'b1000) begin
            $display("FAILED %s flag: expected %b actual %b", cur_test, 4'b1000, cmd_err);
            check_errs++;
        end
        repeat (8) @(negedge memclk);
        if (cmd_err !== 4'b1000) begin
            $display("FAILED %s sticky flag: expected %b actual %b", cur_test, 4'b1000, cmd_err);
            check_errs++;
        end
        finish_test();

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, check_errs);
        if (check_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_evreq_checker.sv ====
module tb_evreq_checker (
    input  logic                memclk,
    input  logic                memresetn,
    input  evreq_pkg::dm_cmd_t  dm_cmd_i,
    input  logic                dm_cmd_valid_i,
    input  logic                dm_cmd_ready_i,
    input  logic                done_valid_i,
    input  logic                done_ready_i,
    input  evreq_pkg::cmpl_t    cmpl_i,
    input  logic                cmpl_valid_i,
    input  logic                cmpl_ready_i
);

    // a stalled command keeps its valid and its data
    cmd_hold_a: assert property (@(posedge memclk) disable iff (!memresetn)
        (dm_cmd_valid_i && !dm_cmd_ready_i) |=> (dm_cmd_valid_i && $stable(dm_cmd_i)))
        else $error("command changed while stalled");

    // the done address is only taken while its source offers one
    done_take_a: assert property (@(posedge memclk) disable iff (!memresetn)
        done_ready_i |-> done_valid_i)
        else $error("done address taken with no done address valid");

    // completions wait unchanged for the consumer
    cmpl_hold_a: assert property (@(posedge memclk) disable iff (!memresetn)
        (cmpl_valid_i && !cmpl_ready_i) |=> (cmpl_valid_i && $stable(cmpl_i)))
        else $error("completion changed while stalled");

endmodule

bind evreq_req_gen tb_evreq_checker u_checker (
    .memclk         (memclk),
    .memresetn      (memresetn),
    .dm_cmd_i       (dm_cmd_o),
    .dm_cmd_valid_i (dm_cmd_valid_o),
    .dm_cmd_ready_i (dm_cmd_ready_i),
    .done_valid_i   (done_valid_i),
    .done_ready_i   (done_ready_o),
    .cmpl_i         (cmpl_o),
    .cmpl_valid_i   (cmpl_valid_o),
    .cmpl_ready_i   (cmpl_ready_i)
);
